//--- all.f
+incdir+include
source/dma_pkg.sv
source/channel_selector.sv
source/sample_packer.sv
source/burst_writer.sv
source/dma_top.sv
sim/axi_slave_model.sv
sim/dma_tb.sv

//--- include/dma_defines.svh
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

////////////////////////////////////////
// DMA writer configuration
////////////////////////////////////////

// Number of acquisition channels served in each run
`define DMA_N_CHANNELS 3

// Samples written per channel in one run
// Must be a multiple of twice the burst length, since every beat carries two samples
`define DMA_CHANNEL_SAMPLES 16

// Beats per AXI write burst
`define DMA_BURST_LEN 4

// Width of the AXI write address
`define DMA_ADDR_WIDTH 32

////////////////////////////////////////
// Fixed data path geometry
////////////////////////////////////////

// One 128 bit beat covers 16 bytes of memory
`define DMA_BEAT_BYTES 16

`endif

//--- sim/axi_slave_model.sv
`timescale 1ns/1ps

module axi_slave_model import dma_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic random_stalls,
    input  aw_t  aw,
    input  logic aw_valid,
    output logic aw_ready,
    input  w_t   w,
    input  logic w_valid,
    output logic w_ready,
    output logic b_valid,
    input  logic b_ready
);

    localparam int max_bursts = 256;
    localparam int max_beats  = 1024;

    // Every accepted address and beat in arrival order
    // The checker in the testbench reads these logs
    aw_t  aw_log [max_bursts];
    w_t   w_log [max_beats];
    int   aw_count;
    int   w_count;

    int   aw_wait;
    int   w_wait;
    int   b_wait;
    logic aw_ready_next;
    logic w_ready_next;
    logic b_valid_next;

    function automatic int stall_cycles();
        return random_stalls ? int'($urandom % 4) : 0;
    endfunction

    initial begin
        aw_ready = 1'b1;
        w_ready  = 1'b1;
        b_valid  = 1'b0;
        aw_count = 0;
        w_count  = 0;
        aw_wait  = 0;
        w_wait   = 0;
        b_wait   = 0;
    end

    ////////////////////////////////////////
    // Handshakes are seen mid cycle
    // New output values go out just after the rising edge
    ////////////////////////////////////////

    always begin
        @(negedge clock);
        aw_ready_next = aw_ready;
        w_ready_next  = w_ready;
        b_valid_next  = b_valid;

        // B is handled first so a fresh delay is not shortened on its own cycle
        if (!reset) begin
            b_valid_next = 1'b0;
            b_wait       = 0;
        end else if (b_valid && b_ready) begin
            b_valid_next = 1'b0;
        end else if (b_wait > 0) begin
            b_wait--;
            b_valid_next = (b_wait == 0);
        end

        if (aw_valid && aw_ready) begin
            if (aw_count < max_bursts) begin
                aw_log[aw_count] = aw;
            end
            aw_count++;
            aw_wait       = stall_cycles();
            aw_ready_next = (aw_wait == 0);
        end else if (!aw_ready) begin
            if (aw_wait > 0) begin
                aw_wait--;
            end
            aw_ready_next = (aw_wait == 0);
        end

        if (w_valid && w_ready) begin
            if (w_count < max_beats) begin
                w_log[w_count] = w;
            end
            w_count++;
            if (w.last) begin
                b_wait = random_stalls ? 1 + int'($urandom % 4) : 1;
            end
            w_wait       = stall_cycles();
            w_ready_next = (w_wait == 0);
        end else if (!w_ready) begin
            if (w_wait > 0) begin
                w_wait--;
            end
            w_ready_next = (w_wait == 0);
        end

        @(posedge clock);
        #2;
        aw_ready = aw_ready_next;
        w_ready  = w_ready_next;
        b_valid  = b_valid_next;
    end

endmodule

//--- sim/dma_tb.sv
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_tb import dma_pkg::*; ();

    localparam int n_tests       = 6;
    localparam int bursts_per_ch = `DMA_CHANNEL_SAMPLES / (2 * `DMA_BURST_LEN);
    localparam int burst_bytes   = `DMA_BURST_LEN * 16;
    localparam int run_limit     = 4000;

    // One run of the DMA
    // A disable_channel of -1 means disable_dma is never raised
    typedef struct {
        logic [`DMA_ADDR_WIDTH-1:0] base;
        logic                       random_stalls;
        logic                       disable_at_start;
        int                         disable_channel;
        string                      name;
    } run_entry_t;

    logic                       clock;
    logic                       reset;
    logic                       buffer_full;
    logic                       disable_dma;
    logic [`DMA_ADDR_WIDTH-1:0] base_addr;
    sample_t                    in_sample [`DMA_N_CHANNELS];
    logic                       in_valid [`DMA_N_CHANNELS];
    logic                       in_ready [`DMA_N_CHANNELS];
    aw_t                        aw;
    logic                       aw_valid;
    logic                       aw_ready;
    w_t                         w;
    logic                       w_valid;
    logic                       w_ready;
    logic                       b_valid;
    logic                       b_ready;
    logic                       done;
    logic                       random_stalls;

    run_entry_t entries [n_tests];
    int         sample_index [`DMA_N_CHANNELS];
    logic       taken [`DMA_N_CHANNELS];
    int         error_count;
    int         failed_tests;

    dma_top DUT (.*);

    axi_slave_model slave (.*);

    always #20 clock = ~clock;

    ////////////////////////////////////////
    // Expected values
    ////////////////////////////////////////

    // Sample i of channel c carries c in the top data byte and i in the low bits
    function automatic sample_t make_sample(int c, int i);
        sample_t s;
        s.user = 16'(i);
        s.dest = 16'(c);
        s.data = (32'(c) << 24) + 32'(i);
        return s;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] expected);
        assert (got === expected) else begin
            $display("error %s: got %0h, expected %0h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic report_test(input int number, input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %0d, %s: passed", number, name);
        end else begin
            $display("test %0d, %s: failed", number, name);
            failed_tests++;
        end
    endtask

    ////////////////////////////////////////
    // Channel sources
    ////////////////////////////////////////

    // Each source moves on to its next sample only after its own handshake
    always begin
        @(negedge clock);
        for (int c = 0; c < `DMA_N_CHANNELS; c++) begin
            taken[c] = in_valid[c] && in_ready[c];
        end
        @(posedge clock);
        #2;
        for (int c = 0; c < `DMA_N_CHANNELS; c++) begin
            if (taken[c]) begin
                sample_index[c]++;
                in_sample[c] = make_sample(c, sample_index[c]);
            end
        end
    end

    task automatic restart_sources();
        for (int c = 0; c < `DMA_N_CHANNELS; c++) begin
            sample_index[c] = 0;
            in_sample[c]    = make_sample(c, 0);
        end
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic check_reset_state();
        int errors_before;
        errors_before = error_count;
        @(negedge clock);
        check_value("aw_valid", aw_valid, 0);
        check_value("w_valid", w_valid, 0);
        check_value("done", done, 0);
        check_value("b_ready", b_ready, 1);
        for (int c = 0; c < `DMA_N_CHANNELS; c++) begin
            check_value($sformatf("in_ready[%0d]", c), in_ready[c], 0);
        end
        @(posedge clock);
        #2;
        report_test(0, "reset state", errors_before);
    endtask

    // Burst k of a run belongs to channel k / bursts_per_ch
    task automatic check_burst(input int k, input aw_t got_aw, input int w_first,
                               input logic [`DMA_ADDR_WIDTH-1:0] base);
        w_t got_w;
        int c;
        int first;
        int j;
        c = k / bursts_per_ch;
        check_value("aw.addr", got_aw.addr, `DMA_ADDR_WIDTH'(base + k * burst_bytes));
        check_value("aw.len", got_aw.len, `DMA_BURST_LEN - 1);
        check_value("aw.size", got_aw.size, 4);
        check_value("aw.burst", got_aw.burst, 1);
        for (j = 0; j < `DMA_BURST_LEN; j++) begin
            got_w = slave.w_log[w_first + j];
            first = ((k % bursts_per_ch) * `DMA_BURST_LEN + j) * 2;
            check_value("w.data", got_w.data, {make_sample(c, first + 1), make_sample(c, first)});
            check_value("w.strb", got_w.strb, 16'hffff);
            check_value("w.last", got_w.last, j == `DMA_BURST_LEN - 1);
        end
    endtask

    task automatic apply_entry(input int t);
        run_entry_t e;
        int         aw_start;
        int         w_start;
        int         channels;
        int         bursts;
        int         limit;
        int         cycles;
        int         done_pulses;
        int         errors_before;
        int         k;
        logic       raise;
        e             = entries[t];
        errors_before = error_count;
        channels      = e.disable_at_start ? 0 :
                        (e.disable_channel >= 0) ? e.disable_channel + 1 : `DMA_N_CHANNELS;
        bursts        = channels * bursts_per_ch;
        limit         = e.disable_at_start ? 50 : run_limit;
        aw_start      = slave.aw_count;
        w_start       = slave.w_count;
        restart_sources();
        random_stalls = e.random_stalls;
        base_addr     = e.base;
        disable_dma   = e.disable_at_start;
        buffer_full   = 1'b1;
        @(posedge clock);
        #2;
        buffer_full = 1'b0;
        cycles      = 0;
        done_pulses = 0;

        // disable_dma goes up once the chosen channel has handed over its first sample
        while (cycles < limit && done_pulses == 0) begin
            @(negedge clock);
            cycles++;
            if (done) begin
                done_pulses++;
            end
            if (e.disable_at_start) begin
                check_value("aw_valid", aw_valid, 0);
            end
            raise = (e.disable_channel >= 0) && (sample_index[e.disable_channel] > 0);
            @(posedge clock);
            #2;
            if (raise) begin
                disable_dma = 1'b1;
            end
        end
        assert (done_pulses > 0 || e.disable_at_start) else begin
            $display("run %0d timed out, done never pulsed in %0d cycles", t + 1, limit);
            error_count++;
        end
        disable_dma = 1'b0;

        // After done the writer stays idle
        repeat (10) begin
            @(negedge clock);
            if (done) begin
                done_pulses++;
            end
            check_value("aw_valid", aw_valid, 0);
            @(posedge clock);
            #2;
        end
        check_value("done pulses", done_pulses, e.disable_at_start ? 0 : 1);
        check_value("aw bursts", slave.aw_count - aw_start, bursts);
        check_value("w beats", slave.w_count - w_start, bursts * `DMA_BURST_LEN);
        for (k = 0; k < bursts; k++) begin
            if (w_start + (k + 1) * `DMA_BURST_LEN <= slave.w_count
                    && aw_start + k < slave.aw_count) begin
                check_burst(k, slave.aw_log[aw_start + k], w_start + k * `DMA_BURST_LEN,
                            e.base);
            end
        end
        for (int c = 0; c < `DMA_N_CHANNELS; c++) begin
            check_value($sformatf("samples taken from channel %0d", c), sample_index[c],
                        (c < channels) ? `DMA_CHANNEL_SAMPLES : 0);
        end
        report_test(t + 1, e.name, errors_before);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        void'($urandom(32'h04e2_17f1));
        entries[0] = '{32'h1000_0000, 1'b0, 1'b0, -1, "full run without stalls"};
        entries[1] = '{32'h1000_0000, 1'b1, 1'b0, -1, "full run with random stalls"};
        entries[2] = '{32'h2000_0400, 1'b1, 1'b0, 1, "disable_dma during channel 1"};
        entries[3] = '{32'h3000_0000, 1'b0, 1'b1, -1, "buffer_full with disable_dma high"};
        entries[4] = '{32'h4000_0000, 1'b1, 1'b0, -1, "first of two runs back to back"};
        entries[5] = '{32'h4abc_0100, 1'b0, 1'b0, -1, "second of two runs back to back"};
        clock         = 1'b0;
        reset         = 1'b0;
        buffer_full   = 1'b0;
        disable_dma   = 1'b0;
        base_addr     = '0;
        random_stalls = 1'b0;
        error_count   = 0;
        failed_tests  = 0;
        for (int c = 0; c < `DMA_N_CHANNELS; c++) begin
            in_valid[c]     = 1'b0;
            in_sample[c]    = '0;
            sample_index[c] = 0;
        end
        repeat (2) @(posedge clock);
        #2;
        reset = 1'b1;
        for (int c = 0; c < `DMA_N_CHANNELS; c++) begin
            in_valid[c] = 1'b1;
        end
        check_reset_state();
        for (int t = 0; t < n_tests; t++) begin
            apply_entry(t);
        end
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 n_tests + 1, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Each table entry gets the cycle budget of one run
    initial begin
        repeat (n_tests * run_limit) @(posedge clock);
        $display("watchdog expired after %0d cycles, the DMA stopped making progress",
                 n_tests * run_limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- source/burst_writer.sv
`timescale 1ns/1ps
`include "dma_defines.svh"

module burst_writer import dma_pkg::*; (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       buffer_full,
    input  logic                       disable_dma,
    input  logic [`DMA_ADDR_WIDTH-1:0] base_addr,
    input  beat_t                      beat,
    input  logic                       beat_valid,
    output logic                       beat_ready,
    output channel_index_t             channel,
    output aw_t                        aw,
    output logic                       aw_valid,
    input  logic                       aw_ready,
    output w_t                         w,
    output logic                       w_valid,
    input  logic                       w_ready,
    input  logic                       b_valid,
    output logic                       b_ready,
    output logic                       done
);

    localparam int addr_width     = `DMA_ADDR_WIDTH;
    localparam int burst_bytes    = `DMA_BURST_LEN * `DMA_BEAT_BYTES;
    localparam int bursts_per_run =
        `DMA_N_CHANNELS * `DMA_CHANNEL_SAMPLES / (2 * `DMA_BURST_LEN);

    localparam int burst_count_width  = (bursts_per_run > 1) ? $clog2(bursts_per_run) : 1;
    localparam int beat_count_width   = (`DMA_BURST_LEN > 1) ? $clog2(`DMA_BURST_LEN) : 1;
    localparam int sample_count_width = $clog2(`DMA_CHANNEL_SAMPLES + 1);

    // AXI encodings for 16 byte beats in incrementing bursts
    localparam logic [2:0] axi_size_16    = 3'd4;
    localparam logic [1:0] axi_burst_incr = 2'b01;

    typedef enum logic [2:0] {
        state_idle,
        state_start_burst,
        state_send,
        state_wait_response,
        state_next_channel
    } state_t;

    state_t                        state;
    logic [addr_width-1:0]         base_q;
    logic [addr_width-1:0]         burst_offset;
    logic [burst_count_width-1:0]  burst_count;
    logic [beat_count_width-1:0]   beat_count;
    logic [sample_count_width-1:0] sample_count;
    channel_index_t                channel_q;
    beat_t                         w_data_q;
    logic                          w_last_q;
    logic                          w_valid_q;
    logic                          done_q;
    logic                          start_run;
    logic                          take_beat;
    logic                          last_channel;
    logic                          channel_full;

    assign start_run    = (state == state_idle) && buffer_full && !disable_dma;
    assign take_beat    = beat_valid && beat_ready;
    assign last_channel = (channel_q == channel_index_t'(`DMA_N_CHANNELS - 1));
    assign channel_full = (sample_count == sample_count_width'(`DMA_CHANNEL_SAMPLES));

    ////////////////////////////////////////
    // AXI outputs
    ////////////////////////////////////////

    // Burst count runs on across channels, so addresses stay consecutive
    assign burst_offset = addr_width'(burst_count) * addr_width'(burst_bytes);

    always_comb begin
        aw.addr  = base_q + burst_offset;
        aw.len   = 8'(`DMA_BURST_LEN - 1);
        aw.size  = axi_size_16;
        aw.burst = axi_burst_incr;
    end

    assign aw_valid = (state == state_start_burst);

    always_comb begin
        w.data = w_data_q;
        w.strb = '1;
        w.last = w_last_q;
    end

    assign w_valid = w_valid_q;

    // A response can only arrive once the final beat of the burst has gone out
    assign b_ready = (state != state_send);

    // One beat in flight on W at a time
    assign beat_ready = (state == state_send) && !w_valid_q;

    assign channel = channel_q;
    assign done    = done_q;

    ////////////////////////////////////////
    // Run control FSM
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            state        <= state_idle;
            burst_count  <= '0;
            beat_count   <= '0;
            sample_count <= '0;
            channel_q    <= '0;
            w_last_q     <= 1'b0;
            w_valid_q    <= 1'b0;
            done_q       <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                state_idle: begin
                    if (start_run) begin
                        burst_count  <= '0;
                        sample_count <= '0;
                        channel_q    <= '0;
                        state        <= state_start_burst;
                    end
                end
                state_start_burst: begin
                    if (aw_ready) begin
                        beat_count <= '0;
                        state      <= state_send;
                    end
                end
                state_send: begin
                    if (take_beat) begin
                        w_valid_q <= 1'b1;
                        w_last_q  <= (beat_count == beat_count_width'(`DMA_BURST_LEN - 1));
                    end
                    // Counts move on the W handshake, not when the beat is taken
                    if (w_valid_q && w_ready) begin
                        w_valid_q    <= 1'b0;
                        beat_count   <= beat_count + 1'b1;
                        sample_count <= sample_count + sample_count_width'(2);
                        if (w_last_q) begin
                            state <= state_wait_response;
                        end
                    end
                end
                state_wait_response: begin
                    if (b_valid) begin
                        if (channel_full) begin
                            state <= state_next_channel;
                        end else begin
                            burst_count <= burst_count + 1'b1;
                            state       <= state_start_burst;
                        end
                    end
                end
                state_next_channel: begin
                    // disable_dma only takes effect here, between channels
                    if (last_channel || disable_dma) begin
                        channel_q   <= '0;
                        burst_count <= '0;
                        done_q      <= 1'b1;
                        state       <= state_idle;
                    end else begin
                        channel_q    <= channel_q + 1'b1;
                        sample_count <= '0;
                        burst_count  <= burst_count + 1'b1;
                        state        <= state_start_burst;
                    end
                end
                default: begin
                    state <= state_idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Payload registers
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (start_run) begin
            base_q <= base_addr;
        end
        if (take_beat) begin
            w_data_q <= beat;
        end
    end

endmodule

//--- source/channel_selector.sv
`timescale 1ns/1ps
`include "dma_defines.svh"

module channel_selector import dma_pkg::*; (
    input  logic           clock,
    input  logic           reset,
    input  channel_index_t channel,
    input  sample_t        in_sample [`DMA_N_CHANNELS],
    input  logic           in_valid [`DMA_N_CHANNELS],
    output logic           in_ready [`DMA_N_CHANNELS],
    output sample_t        sel_sample,
    output logic           sel_valid,
    input  logic           sel_ready
);

    logic           in_range;
    logic           range_fault;
    channel_index_t active;

    // The index width can encode more values than there are channels
    assign in_range = (int'(channel) < `DMA_N_CHANNELS);

    // Sticky range flag
    // Once a bad index has been seen the selector stays on channel 0
    always_ff @(posedge clock) begin
        if (!reset) begin
            range_fault <= 1'b0;
        end else if (!in_range) begin
            range_fault <= 1'b1;
        end
    end

    assign active = (in_range && !range_fault) ? channel : '0;

    ////////////////////////////////////////
    // Forward path
    ////////////////////////////////////////

    assign sel_sample = in_sample[active];
    assign sel_valid  = in_valid[active];

    ////////////////////////////////////////
    // Ready return path
    ////////////////////////////////////////

    // Only the active channel ever sees ready high
    always_comb begin
        for (int c = 0; c < `DMA_N_CHANNELS; c++) begin
            in_ready[c] = sel_ready && (active == channel_index_t'(c));
        end
    end

endmodule

//--- source/dma_pkg.sv
`include "dma_defines.svh"

package dma_pkg;

    ////////////////////////////////////////
    // Stream payloads
    ////////////////////////////////////////

    // One acquisition sample as it is stored in memory
    // The user tag sits in the top bits and the data in the bottom bits
    typedef struct packed {
        logic [15:0] user;
        logic [15:0] dest;
        logic [31:0] data;
    } sample_t;

    // A full write beat holds two samples, the earlier one in the low half
    typedef logic [127:0] beat_t;

    ////////////////////////////////////////
    // AXI write channels
    ////////////////////////////////////////

    // Write address channel payload
    typedef struct packed {
        logic [`DMA_ADDR_WIDTH-1:0] addr;
        logic [7:0]                 len;
        logic [2:0]                 size;
        logic [1:0]                 burst;
    } aw_t;

    // Write data channel payload
    typedef struct packed {
        beat_t       data;
        logic [15:0] strb;
        logic        last;
    } w_t;

    ////////////////////////////////////////
    // Channel indexing
    ////////////////////////////////////////

    // A single channel still needs one index bit
    localparam int channel_index_width =
        (`DMA_N_CHANNELS > 1) ? $clog2(`DMA_N_CHANNELS) : 1;

    typedef logic [channel_index_width-1:0] channel_index_t;

endpackage

//--- source/dma_top.sv
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_top import dma_pkg::*; (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       buffer_full,
    input  logic                       disable_dma,
    input  logic [`DMA_ADDR_WIDTH-1:0] base_addr,
    input  sample_t                    in_sample [`DMA_N_CHANNELS],
    input  logic                       in_valid [`DMA_N_CHANNELS],
    output logic                       in_ready [`DMA_N_CHANNELS],
    output aw_t                        aw,
    output logic                       aw_valid,
    input  logic                       aw_ready,
    output w_t                         w,
    output logic                       w_valid,
    input  logic                       w_ready,
    input  logic                       b_valid,
    output logic                       b_ready,
    output logic                       done
);

    channel_index_t channel;
    sample_t        sel_sample;
    logic           sel_valid;
    logic           sel_ready;
    beat_t          beat;
    logic           beat_valid;
    logic           beat_ready;

    ////////////////////////////////////////
    // Channel selection
    ////////////////////////////////////////

    channel_selector selector (
        .clock      (clock),
        .reset      (reset),
        .channel    (channel),
        .in_sample  (in_sample),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .sel_sample (sel_sample),
        .sel_valid  (sel_valid),
        .sel_ready  (sel_ready)
    );

    ////////////////////////////////////////
    // Sample pairing
    ////////////////////////////////////////

    sample_packer packer (
        .clock      (clock),
        .reset      (reset),
        .in_sample  (sel_sample),
        .in_valid   (sel_valid),
        .in_ready   (sel_ready),
        .beat       (beat),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready)
    );

    ////////////////////////////////////////
    // AXI burst writer
    ////////////////////////////////////////

    burst_writer writer (
        .clock       (clock),
        .reset       (reset),
        .buffer_full (buffer_full),
        .disable_dma (disable_dma),
        .base_addr   (base_addr),
        .beat        (beat),
        .beat_valid  (beat_valid),
        .beat_ready  (beat_ready),
        .channel     (channel),
        .aw          (aw),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .w           (w),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .b_valid     (b_valid),
        .b_ready     (b_ready),
        .done        (done)
    );

endmodule

//--- source/sample_packer.sv
`timescale 1ns/1ps

module sample_packer import dma_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  sample_t in_sample,
    input  logic    in_valid,
    output logic    in_ready,
    output beat_t   beat,
    output logic    beat_valid,
    input  logic    beat_ready
);

    sample_t half_sample;
    logic    half_full;
    logic    beat_pending;
    beat_t   beat_q;
    logic    accept;
    logic    complete;

    ////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////

    // Words are only drawn while the writer is ready for a beat
    // This keeps the packer empty while the writer is idle or waiting on AXI
    assign in_ready = beat_ready && !beat_pending;
    assign accept   = in_valid && in_ready;

    // The second word of a pair closes the beat
    assign complete = accept && half_full;

    assign beat       = beat_q;
    assign beat_valid = beat_pending;

    ////////////////////////////////////////
    // Pairing control
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            half_sample  <= '0;
            half_full    <= 1'b0;
            beat_pending <= 1'b0;
        end else begin
            if (beat_pending && beat_ready) begin
                beat_pending <= 1'b0;
            end
            if (accept) begin
                if (half_full) begin
                    half_full    <= 1'b0;
                    beat_pending <= 1'b1;
                end else begin
                    half_sample <= in_sample;
                    half_full   <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Beat assembly
    ////////////////////////////////////////

    // Earlier sample goes to the low 64 bits
    always_ff @(posedge clock) begin
        if (complete) begin
            beat_q <= {in_sample, half_sample};
        end
    end

endmodule
